// ==== src/fir_settings.svh ====
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// number of filter taps, keep a power of two so the tap index wraps for free
`define FIR_TAPS 8

// input sample width, two's complement
`define SAMPLE_W 24

// coefficient width, two's complement
`define COEF_W 8

// extra bits above the product so a full burst of FIR_TAPS products fits
`define ACC_GUARD 3

`endif

// ==== src/fir_pkg.sv ====
`default_nettype none

`include "fir_settings.svh"

package fir_pkg;

  // datapath words
  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  typedef logic signed [`COEF_W-1:0] coef_t;
  typedef logic signed [`SAMPLE_W+`COEF_W-1:0] product_t;
  typedef logic signed [`SAMPLE_W+`COEF_W+`ACC_GUARD-1:0] acc_t;

  typedef logic [$clog2(`FIR_TAPS)-1:0] tap_idx_t; // also a delay line slot

  // sequencer states
  typedef enum logic [1:0] {
    IDLE,  // waiting for a sample strobe
    ISSUE, // one tap per clock into the multiplier
    DRAIN, // products still in the pipeline
    DONE   // accumulator presents the result
  } fir_state_t;

endpackage

`default_nettype wire

// ==== src/shift_multiplier.sv ====
`default_nettype none

`include "fir_settings.svh"

module shift_multiplier #(
  parameter int M_width = `SAMPLE_W,
  parameter int Q_width = `COEF_W
) (
  input  logic                              Clock,
  input  logic                              Rst,
  input  logic signed [M_width-1:0]         mu,        // multiplicand
  input  logic signed [Q_width-1:0]         qu,        // multiplier
  input  logic                              in_valid,
  input  logic                              in_last,
  output logic signed [M_width+Q_width-1:0] product,
  output logic                              out_valid,
  output logic                              out_last
);

localparam int P_width = M_width + Q_width;

logic [M_width-1:0] abs_mu;
logic [Q_width-1:0] abs_qu;
logic               neg;

// per stage registers, index 0 is the capture stage
logic [P_width-1:0] st_acc   [1:Q_width];   // partial sums begin at stage 1
logic [M_width-1:0] st_mu    [0:Q_width-1];
logic [Q_width-1:0] st_qu    [0:Q_width-1];
logic               st_neg   [0:Q_width];
logic               st_valid [0:Q_width];
logic               st_last  [0:Q_width];

////////////////////////////////////////////////////////////////////////////
// stage 0: magnitudes and result sign

assign abs_mu = mu[M_width-1] ? M_width'(-mu) : M_width'(mu); // -2^(M-1) stays exact as unsigned
assign abs_qu = qu[Q_width-1] ? Q_width'(-qu) : Q_width'(qu);
assign neg    = mu[M_width-1] ^ qu[Q_width-1]; // zero magnitude makes the sign harmless

always_ff @(posedge Clock) begin
  st_mu[0]  <= abs_mu;
  st_qu[0]  <= abs_qu;
  st_neg[0] <= neg;
end

////////////////////////////////////////////////////////////////////////////
// stages 1..Q_width: one partial product each

always_ff @(posedge Clock) begin
  // first stage starts the sum from the lowest multiplier bit
  st_acc[1] <= st_qu[0][0] ? P_width'(st_mu[0]) : '0;
  for (int i = 1; i < Q_width; i++) begin
    if (st_qu[i][0]) begin
      st_acc[i+1] <= st_acc[i] + (P_width'(st_mu[i]) << i);
    end else begin
      st_acc[i+1] <= st_acc[i];
    end
  end
  for (int i = 0; i < Q_width - 1; i++) begin
    st_mu[i+1] <= st_mu[i];
    st_qu[i+1] <= st_qu[i] >> 1; // next multiplier bit into position 0
  end
  for (int i = 0; i < Q_width; i++) begin
    st_neg[i+1] <= st_neg[i];
  end
end

// flags travel with their data
always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    for (int i = 0; i <= Q_width; i++) begin
      st_valid[i] <= 1'b0;
      st_last[i]  <= 1'b0;
    end
  end else begin
    st_valid[0] <= in_valid;
    st_last[0]  <= in_valid && in_last;
    for (int i = 0; i < Q_width; i++) begin
      st_valid[i+1] <= st_valid[i];
      st_last[i+1]  <= st_last[i];
    end
  end
end

// restore the sign on the way out
assign product   = st_neg[Q_width] ? -$signed(st_acc[Q_width]) : $signed(st_acc[Q_width]);
assign out_valid = st_valid[Q_width];
assign out_last  = st_last[Q_width];

// fixed latency, the sequencer and accumulator count on it
a_latency: assert property (@(posedge Clock) disable iff (Rst)
  out_valid == $past(in_valid, Q_width + 1))
  else $error("multiplier output valid out of step with its input");

endmodule

`default_nettype wire

// ==== src/coef_bank.sv ====
`default_nettype none

`include "fir_settings.svh"

module coef_bank
  import fir_pkg::*;
(
  input  logic     Clock,
  input  logic     Rst,
  input  logic     we,     // write strobe from the host
  input  tap_idx_t waddr,
  input  coef_t    wdata,
  input  logic     busy,   // filter running, writes not allowed
  input  tap_idx_t raddr,  // tap being issued
  output coef_t    rdata
);

coef_t coefs [`FIR_TAPS];

always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    for (int i = 0; i < `FIR_TAPS; i++) begin
      coefs[i] <= '0; // all taps start at zero
    end
  end else if (we && !busy) begin
    coefs[waddr] <= wdata;
  end
end

assign rdata = coefs[raddr];

// a write during a burst would mix two coefficient sets in one result
a_no_write_busy: assert property (@(posedge Clock) disable iff (Rst)
  !(we && busy))
  else $error("coefficient write while the filter is busy");

endmodule

`default_nettype wire

// ==== src/sample_delay_line.sv ====
`default_nettype none

`include "fir_settings.svh"

module sample_delay_line
  import fir_pkg::*;
(
  input  logic     Clock,
  input  logic     Rst,
  input  logic     push,     // accepted sample strobe
  input  sample_t  din,
  input  tap_idx_t tap_idx,  // 0 is the newest sample
  output sample_t  dout
);

sample_t  slots [`FIR_TAPS];
tap_idx_t newest;   // slot holding x[n]
tap_idx_t wr_ptr;
tap_idx_t rd_ptr;

// pointers wrap at FIR_TAPS through the index width
assign wr_ptr = newest + 1'b1;
assign rd_ptr = newest - tap_idx;

always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    newest <= '0;
  end else if (push) begin
    newest <= wr_ptr;
  end
end

// history before the first FIR_TAPS pushes reads as zero
always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    for (int i = 0; i < `FIR_TAPS; i++) begin
      slots[i] <= '0;
    end
  end else if (push) begin
    slots[wr_ptr] <= din; // oldest sample is overwritten
  end
end

assign dout = slots[rd_ptr]; // x[n - tap_idx]

endmodule

`default_nettype wire

// ==== src/mac_accumulator.sv ====
`default_nettype none

`include "fir_settings.svh"

module mac_accumulator
  import fir_pkg::*;
(
  input  logic     Clock,
  input  logic     Rst,
  input  logic     prod_valid,
  input  logic     prod_last,   // final product of the burst
  input  product_t product,
  output logic     result_valid,
  output acc_t     result_data
);

acc_t prod_ext;
acc_t sum;
logic pending;  // burst complete, total waiting to be presented

assign prod_ext = {{`ACC_GUARD{product[$bits(product_t)-1]}}, product}; // sign extend

always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    sum          <= '0;
    pending      <= 1'b0;
    result_valid <= 1'b0;
  end else begin
    result_valid <= pending;
    if (pending) begin
      sum     <= '0;  // ready for the next burst
      pending <= 1'b0;
    end else if (prod_valid) begin
      sum     <= sum + prod_ext;
      pending <= prod_last;
    end
  end
end

// result holds until the next burst ends
always_ff @(posedge Clock) begin
  if (pending) begin
    result_data <= sum;
  end
end

endmodule

`default_nettype wire

// ==== src/fir_sequencer.sv ====
`default_nettype none

`include "fir_settings.svh"

module fir_sequencer
  import fir_pkg::*;
(
  input  logic     Clock,
  input  logic     Rst,
  input  logic     sample_valid, // host sample strobe
  input  logic     prod_last,    // last product leaving the multiplier
  output logic     push,         // write the sample into the delay line
  output tap_idx_t tap_idx,      // read address for both banks
  output logic     mul_issue,
  output logic     issue_last,
  output logic     busy
);

fir_state_t state;
fir_state_t state_nxt;
tap_idx_t   tap_cnt;
logic       last_tap;

assign last_tap = (tap_cnt == tap_idx_t'(`FIR_TAPS - 1));

////////////////////////////////////////////////////////////////////////////
// state machine

always_comb begin
  state_nxt = state;
  case (state)
    IDLE: begin
      if (sample_valid) begin
        state_nxt = ISSUE;
      end
    end
    ISSUE: begin
      if (last_tap) begin
        state_nxt = DRAIN;
      end
    end
    DRAIN: begin
      if (prod_last) begin
        state_nxt = DONE;
      end
    end
    DONE: begin
      state_nxt = IDLE; // accumulator registers its total this cycle
    end
    default: begin
      state_nxt = IDLE;
    end
  endcase
end

always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    state <= IDLE;
  end else begin
    state <= state_nxt;
  end
end

// tap counter, one step per issued tap
always_ff @(posedge Clock or posedge Rst) begin
  if (Rst) begin
    tap_cnt <= '0;
  end else if (push) begin
    tap_cnt <= '0;
  end else if (state == ISSUE) begin
    tap_cnt <= tap_cnt + 1'b1;
  end
end

////////////////////////////////////////////////////////////////////////////
// outputs

assign push       = sample_valid && (state == IDLE); // strobes while busy are dropped
assign busy       = (state != IDLE);
assign mul_issue  = (state == ISSUE);
assign issue_last = mul_issue && last_tap;
assign tap_idx    = tap_cnt;

a_no_sample_busy: assert property (@(posedge Clock) disable iff (Rst)
  !(sample_valid && busy))
  else $error("sample strobe while the filter is busy");

// the burst end tag must come back through the multiplier pipeline
a_last_returns: assert property (@(posedge Clock) disable iff (Rst)
  issue_last |-> ##(`COEF_W + 1) (prod_last && state == DRAIN))
  else $error("last tap did not leave the multiplier on time");

endmodule

`default_nettype wire

// ==== src/fir_mac_top.sv ====
`default_nettype none

`include "fir_settings.svh"

module fir_mac_top
  import fir_pkg::*;
(
  input  logic     Clock,
  input  logic     Rst,
  input  logic     coef_we,
  input  tap_idx_t coef_addr,
  input  coef_t    coef_wdata,
  input  logic     sample_valid,
  input  sample_t  sample_data,
  output logic     busy,
  output logic     result_valid,
  output acc_t     result_data
);

logic     push;
tap_idx_t tap_idx;
logic     mul_issue;
logic     issue_last;
coef_t    tap_coef;    // c[tap_idx]
sample_t  tap_sample;  // x[n - tap_idx]
product_t product;
logic     prod_valid;
logic     prod_last;

fir_sequencer seq_i (
  .Clock        (Clock),
  .Rst          (Rst),
  .sample_valid (sample_valid),
  .prod_last    (prod_last),
  .push         (push),
  .tap_idx      (tap_idx),
  .mul_issue    (mul_issue),
  .issue_last   (issue_last),
  .busy         (busy)
);

coef_bank coef_i (
  .Clock (Clock),
  .Rst   (Rst),
  .we    (coef_we),
  .waddr (coef_addr),
  .wdata (coef_wdata),
  .busy  (busy),
  .raddr (tap_idx),
  .rdata (tap_coef)
);

sample_delay_line delay_i (
  .Clock   (Clock),
  .Rst     (Rst),
  .push    (push),
  .din     (sample_data),
  .tap_idx (tap_idx),
  .dout    (tap_sample)
);

shift_multiplier #(
  .M_width (`SAMPLE_W),
  .Q_width (`COEF_W)
) mul_i (
  .Clock     (Clock),
  .Rst       (Rst),
  .mu        (tap_sample),
  .qu        (tap_coef),
  .in_valid  (mul_issue),
  .in_last   (issue_last),
  .product   (product),
  .out_valid (prod_valid),
  .out_last  (prod_last)
);

mac_accumulator acc_i (
  .Clock        (Clock),
  .Rst          (Rst),
  .prod_valid   (prod_valid),
  .prod_last    (prod_last),
  .product      (product),
  .result_valid (result_valid),
  .result_data  (result_data)
);

endmodule

`default_nettype wire

// ==== tb/fir_checker.sv ====
`default_nettype none

`include "fir_settings.svh"

module fir_checker
  import fir_pkg::*;
(
  input wire logic     Clock,
  input wire logic     Rst,
  input wire logic     coef_we,
  input wire tap_idx_t coef_addr,
  input wire coef_t    coef_wdata,
  input wire logic     sample_valid,
  input wire sample_t  sample_data,
  input wire logic     busy,
  input wire logic     result_valid,
  input wire acc_t     result_data
);

timeunit 1ns;
timeprecision 1ps;

localparam int RESULT_EDGE = 18; // accepting edge to result_valid

int     error_count;
int     result_count;
longint coefs [`FIR_TAPS];
longint hist  [`FIR_TAPS];   // hist[0] is the newest sample
bit     fixed_has_q [$];     // one entry per sample the testbench strobes
acc_t   fixed_val_q [$];
bit     cur_has;
acc_t   cur_fixed;
acc_t   expected;
bit     active;
int     cnt;

// the testbench queues a known answer, or none, for each sample
task automatic expect_value(input bit has, input acc_t v);
  fixed_has_q.push_back(has);
  fixed_val_q.push_back(v);
endtask

////////////////////////////////////////////////////////////////////////////
// reference model and burst timing

always @(posedge Clock) begin
  longint sum;
  if (Rst) begin
    for (int i = 0; i < `FIR_TAPS; i++) begin
      coefs[i] = 0;
      hist[i]  = 0;
    end
    active = 1'b0;
    cnt    = 0;
  end else if (active) begin
    cnt++;
    if (cnt <= RESULT_EDGE) begin
      if (!busy) begin
        $display("busy dropped %0d cycles into a burst", cnt);
        error_count++;
      end
      if (result_valid) begin
        $display("result_valid rose early, %0d cycles after the sample", cnt - 1);
        error_count++;
      end
    end else begin
      if (!result_valid) begin
        $display("result_valid did not rise %0d cycles after the sample", RESULT_EDGE);
        error_count++;
      end else begin
        result_count++;
        if (result_data !== expected) begin
          $display("CHECK FAILED result_data: expected %h, got %h", expected, result_data);
          error_count++;
        end
        if (cur_has && result_data !== cur_fixed) begin
          $display("CHECK FAILED result_data: table value %h, got %h", cur_fixed, result_data);
          error_count++;
        end
      end
      if (busy) begin
        $display("busy still high in the result cycle");
        error_count++;
      end
      active = 1'b0;
    end
  end else begin
    // idle: no pulse may linger and busy must stay low
    if (result_valid) begin
      $display("result_valid high with no result due");
      error_count++;
    end
    if (busy) begin
      $display("busy high with no sample in flight");
      error_count++;
    end
    if (coef_we) begin
      coefs[coef_addr] = longint'(coef_wdata);
    end
    if (sample_valid) begin
      for (int k = `FIR_TAPS - 1; k > 0; k--) begin
        hist[k] = hist[k-1];
      end
      hist[0] = longint'(sample_data);
      sum = 0;
      for (int k = 0; k < `FIR_TAPS; k++) begin
        sum += coefs[k] * hist[k]; // c[k] * x[n-k]
      end
      expected = acc_t'(sum);
      if (fixed_has_q.size() > 0) begin
        cur_has   = fixed_has_q.pop_front();
        cur_fixed = fixed_val_q.pop_front();
      end else begin
        cur_has = 1'b0;
      end
      active = 1'b1;
      cnt    = 0;
    end
  end
end

endmodule

`default_nettype wire

// ==== tb/fir_tb.sv ====
`default_nettype none

`include "fir_settings.svh"

module fir_tb
  import fir_pkg::*;
;

timeunit 1ns;
timeprecision 1ps;

localparam int TABLE_LEN = 104;
localparam int TIMEOUT   = TABLE_LEN * 20 + 100;
localparam bit OP_COEF   = 1'b0;
localparam bit OP_SAMPLE = 1'b1;

logic     Clock;
logic     Rst;
logic     coef_we;
tap_idx_t coef_addr;
coef_t    coef_wdata;
logic     sample_valid;
sample_t  sample_data;
logic     busy;
logic     result_valid;
acc_t     result_data;

// stimulus table
bit          op_tab      [TABLE_LEN];
tap_idx_t    addr_tab    [TABLE_LEN];
logic [23:0] data_tab    [TABLE_LEN];
bit          has_exp_tab [TABLE_LEN];
acc_t        exp_tab     [TABLE_LEN];
int          n_entries;
int          n_samples;
int          run_errors;
int          cycles;
integer      seed;

fir_mac_top dut_i (.*);
fir_checker chk_i (.*);

initial begin
  Clock = 1'b0;
  forever #4 Clock = ~Clock;
end

task automatic add_entry(input bit op, input int addr, input logic [23:0] data,
                         input bit has, input longint expv);
  op_tab[n_entries]      = op;
  addr_tab[n_entries]    = tap_idx_t'(addr);
  data_tab[n_entries]    = data;
  has_exp_tab[n_entries] = has;
  exp_tab[n_entries]     = acc_t'(expv);
  n_entries++;
endtask

task automatic build_table();
  int c [`FIR_TAPS];
  c = '{3, -5, 7, -11, 13, -17, 19, -23};
  add_entry(OP_SAMPLE, 0, 24'h123456, 1, 0); // all coefficients still zero
  for (int k = 0; k < `FIR_TAPS; k++) add_entry(OP_COEF, k, 24'(c[k]), 0, 0);
  for (int k = 0; k < 7; k++) add_entry(OP_SAMPLE, 0, 24'h0, 0, 0); // flush history
  add_entry(OP_SAMPLE, 0, 24'h1, 1, c[0]); // impulse
  for (int k = 1; k < `FIR_TAPS; k++) add_entry(OP_SAMPLE, 0, 24'h0, 1, c[k]);
  // signed extremes
  for (int k = 0; k < `FIR_TAPS; k++) add_entry(OP_COEF, k, k[0] ? 24'h7f : 24'h80, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h800000, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h7fffff, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h000000, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h800000, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h800000, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h800000, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h7fffff, 0, 0);
  add_entry(OP_SAMPLE, 0, 24'h000000, 0, 0);
  // two random coefficient sets, 24 random samples each
  for (int s = 0; s < 2; s++) begin
    for (int k = 0; k < `FIR_TAPS; k++) add_entry(OP_COEF, k, 24'($random(seed)), 0, 0);
    for (int k = 0; k < 24; k++) add_entry(OP_SAMPLE, 0, 24'($random(seed)), 0, 0);
  end
endtask

task automatic apply_entry(input int i);
  @(posedge Clock);
  while (busy) @(posedge Clock); // host waits for the filter to go idle
  if (op_tab[i] == OP_COEF) begin
    coef_we    <= 1'b1;
    coef_addr  <= addr_tab[i];
    coef_wdata <= coef_t'(data_tab[i][7:0]);
  end else begin
    chk_i.expect_value(has_exp_tab[i], exp_tab[i]);
    sample_valid <= 1'b1;
    sample_data  <= sample_t'(data_tab[i]);
    n_samples++;
  end
  @(posedge Clock);
  coef_we      <= 1'b0;
  sample_valid <= 1'b0;
endtask

// run limit
always @(posedge Clock) begin
  cycles++;
  if (cycles >= TIMEOUT) begin
    $display("timeout after %0d cycles, the run did not finish", cycles);
    $display("Regression failed");
    $finish;
  end
end

initial begin
  int total;
  seed         = 32'hedda44ea;
  Rst          = 1'b1;
  coef_we      = 1'b0;
  coef_addr    = '0;
  coef_wdata   = '0;
  sample_valid = 1'b0;
  sample_data  = '0;
  cycles       = 0;
  build_table();
  repeat (16) @(posedge Clock);
  Rst <= 1'b0;
  for (int i = 0; i < n_entries; i++) apply_entry(i);
  @(posedge Clock);
  while (busy) @(posedge Clock);
  repeat (4) @(posedge Clock);
  if (chk_i.result_count != n_samples) begin
    $display("%0d samples sent but %0d results seen", n_samples, chk_i.result_count);
    run_errors++;
  end
  total = chk_i.error_count + run_errors;
  $display("errors: checker %0d, run %0d, total %0d", chk_i.error_count, run_errors, total);
  if (total == 0) begin
    $display("Regression passed");
  end else begin
    $display("Regression failed");
  end
  $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/fir_pkg.sv
src/shift_multiplier.sv
src/coef_bank.sv
src/sample_delay_line.sv
src/mac_accumulator.sv
src/fir_sequencer.sv
src/fir_mac_top.sv
tb/fir_checker.sv
tb/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module fir_tb \
  -f compile.f

./obj_dir/Vfir_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
fi
exit 1
